// ==== Bender.yml ====
package:
  name: muldiv

sources:
  - hw/muldiv_pkg.sv
  - hw/seq_divider.sv
  - hw/muldiv_decode.sv
  - hw/muldiv_execute.sv
  - hw/hilo_result.sv
  - hw/muldiv_top.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/muldiv_asserts.sv
      - sim/muldiv_tb.sv

// ==== filelist.f ====
hw/muldiv_pkg.sv
hw/seq_divider.sv
hw/muldiv_decode.sv
hw/muldiv_execute.sv
hw/hilo_result.sv
hw/muldiv_top.sv
sim/clk_gen.sv
sim/muldiv_asserts.sv
sim/muldiv_tb.sv

// ==== hw/hilo_result.sv ====
module hilo_result (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ex_valid,
    input  logic [muldiv_pkg::HILO_W-1:0] ex_value,
    input  muldiv_pkg::wb_kind_t          wb_kind,
    input  logic                          res_ready,
    output logic                          res_valid,
    output logic [muldiv_pkg::HILO_W-1:0] hilo,
    output logic                          res_done
);

    logic [muldiv_pkg::HILO_W-1:0] hilo_q;

    assign hilo     = hilo_q;
    assign res_done = res_valid && res_ready;

    // decode holds off new requests until res_done,
    // so ex_valid never arrives while a result is waiting
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hilo_q    <= '0;
            res_valid <= 1'b0;
        end else begin
            if (ex_valid) begin
                case (wb_kind)
                    muldiv_pkg::WB_ADD: hilo_q <= hilo_q + ex_value;
                    muldiv_pkg::WB_SUB: hilo_q <= hilo_q - ex_value;
                    default:            hilo_q <= ex_value;
                endcase
                res_valid <= 1'b1;
            end else if (res_done) begin
                res_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/muldiv_decode.sv ====
module muldiv_decode (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,
    input  logic                          in_valid,
    input  logic [muldiv_pkg::OP_W-1:0]   op,
    input  logic                          is_unsigned,
    input  logic [muldiv_pkg::XLEN-1:0]   operand_a,
    input  logic [muldiv_pkg::XLEN-1:0]   operand_b,
    input  logic                          res_done,
    output logic                          in_ready,
    output logic                          issue,
    output logic                          is_div,
    output logic                          is_move,
    output logic                          is_unsigned_q,
    output muldiv_pkg::wb_kind_t          wb_kind,
    output logic [muldiv_pkg::XLEN-1:0]   operand_a_q,
    output logic [muldiv_pkg::XLEN-1:0]   operand_b_q
);

    muldiv_pkg::op_t      op_e;
    muldiv_pkg::div_cnt_t cancel_cnt;
    logic                 busy;
    logic                 accept;
    logic                 div_req;

    assign op_e     = muldiv_pkg::op_t'(op);
    assign div_req  = (op_e == muldiv_pkg::OP_DIV);
    assign in_ready = !busy && !flush;
    assign accept   = in_valid && in_ready;

    // busy covers the whole operation, from acceptance until the result handshake.
    // cancel_cnt counts the cycles in which a flush can still stop the write to HI/LO;
    // once it reaches zero the result is committed and only res_done frees the unit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            issue      <= 1'b0;
            cancel_cnt <= '0;
        end else begin
            issue <= accept;
            if (accept) begin
                busy <= 1'b1;
                if (div_req) begin
                    cancel_cnt <= muldiv_pkg::div_cnt_t'(muldiv_pkg::DIV_CYCLES + 2);
                end else begin
                    cancel_cnt <= muldiv_pkg::div_cnt_t'(1);
                end
            end else begin
                if (res_done || (flush && cancel_cnt != '0)) begin
                    busy <= 1'b0;
                end
                if (flush) begin
                    cancel_cnt <= '0;
                end else if (cancel_cnt != '0) begin
                    cancel_cnt <= cancel_cnt - 1'b1;
                end
            end
        end
    end

    // request payload, only meaningful while issue is high
    always_ff @(posedge clk) begin
        if (accept) begin
            operand_a_q   <= operand_a;
            operand_b_q   <= operand_b;
            is_unsigned_q <= is_unsigned;
            is_div        <= div_req;
            is_move       <= (op_e == muldiv_pkg::OP_MTHILO);
            case (op_e)
                muldiv_pkg::OP_MADD: wb_kind <= muldiv_pkg::WB_ADD;
                muldiv_pkg::OP_MSUB: wb_kind <= muldiv_pkg::WB_SUB;
                default:             wb_kind <= muldiv_pkg::WB_SET;
            endcase
        end
    end

endmodule

// ==== hw/muldiv_execute.sv ====
module muldiv_execute (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,
    input  logic                          issue,
    input  logic                          is_div,
    input  logic                          is_move,
    input  logic                          is_unsigned,
    input  muldiv_pkg::wb_kind_t          wb_kind,
    input  logic [muldiv_pkg::XLEN-1:0]   operand_a,
    input  logic [muldiv_pkg::XLEN-1:0]   operand_b,
    output logic                          ex_valid,
    output logic [muldiv_pkg::HILO_W-1:0] ex_value,
    output muldiv_pkg::wb_kind_t          ex_wb_kind
);

    localparam int W = muldiv_pkg::XLEN;

    logic [W-1:0]                   mag_a;
    logic [W-1:0]                   mag_b;
    logic                           sign_diff;
    logic                           div_start;
    logic                           div_done;
    logic [W-1:0]                   div_quo;
    logic [W-1:0]                   div_rem;
    logic [W-1:0]                   quo_fix;
    logic [W-1:0]                   rem_fix;
    logic [muldiv_pkg::HILO_W-1:0]  val_q;
    logic [muldiv_pkg::HILO_W-1:0]  div_res_q;
    logic                           neg_q;
    logic                           rem_neg_q;
    logic                           div_zero_q;
    logic                           mul_valid_q;
    logic                           div_valid_q;

    // signed operands are handled as magnitudes, signs are restored afterwards
    assign mag_a     = (is_unsigned || !operand_a[W-1]) ? operand_a : -operand_a;
    assign mag_b     = (is_unsigned || !operand_b[W-1]) ? operand_b : -operand_b;
    assign sign_diff = !is_unsigned && (operand_a[W-1] ^ operand_b[W-1]);
    assign div_start = issue && is_div;

    seq_divider u_divider (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .abort     (flush),
        .dividend  (mag_a),
        .divisor   (mag_b),
        .quotient  (div_quo),
        .remainder (div_rem),
        .done      (div_done)
    );

    // for a divide, val_q keeps the divide-by-zero result {operand_a, all ones}
    always_ff @(posedge clk) begin
        if (issue) begin
            if (is_move) begin
                val_q <= {operand_a, operand_b};
            end else if (is_div) begin
                val_q <= {operand_a, {W{1'b1}}};
            end else begin
                val_q <= {{W{1'b0}}, mag_a} * {{W{1'b0}}, mag_b};
            end
            neg_q      <= sign_diff && !is_move;
            rem_neg_q  <= !is_unsigned && operand_a[W-1];
            div_zero_q <= (operand_b == '0);
            ex_wb_kind <= wb_kind;
        end
    end

    // quotient negated on differing signs, remainder follows the dividend
    assign quo_fix = neg_q ? -div_quo : div_quo;
    assign rem_fix = rem_neg_q ? -div_rem : div_rem;

    always_ff @(posedge clk) begin
        if (div_done) begin
            div_res_q <= div_zero_q ? val_q : {rem_fix, quo_fix};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mul_valid_q <= 1'b0;
            div_valid_q <= 1'b0;
        end else begin
            mul_valid_q <= issue && !is_div && !flush;
            div_valid_q <= div_done && !flush;
        end
    end

    assign ex_valid = mul_valid_q || div_valid_q;
    assign ex_value = div_valid_q ? div_res_q : (neg_q ? -val_q : val_q);

endmodule

// ==== hw/muldiv_pkg.sv ====
package muldiv_pkg;

    // operand and accumulator widths
    localparam int XLEN   = 32;
    localparam int HILO_W = 2 * XLEN;
    localparam int OP_W   = 3;

    // one quotient bit per divider iteration
    localparam int DIV_CYCLES = 32;

    // counters must also hold the decode cancel window of DIV_CYCLES + 2
    localparam int DIV_CNT_W = $clog2(DIV_CYCLES + 3);

    typedef logic [DIV_CNT_W-1:0] div_cnt_t;

    typedef enum logic [OP_W-1:0] {
        OP_MULT   = 3'd0,
        OP_MADD   = 3'd1,
        OP_MSUB   = 3'd2,
        OP_DIV    = 3'd3,
        OP_MTHILO = 3'd4
    } op_t;

    // how a finished result is merged into HI/LO
    typedef enum logic [1:0] {
        WB_SET = 2'd0,
        WB_ADD = 2'd1,
        WB_SUB = 2'd2
    } wb_kind_t;

endpackage

// ==== hw/muldiv_top.sv ====
module muldiv_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,
    input  logic                          in_valid,
    input  logic [muldiv_pkg::OP_W-1:0]   op,
    input  logic                          is_unsigned,
    input  logic [muldiv_pkg::XLEN-1:0]   operand_a,
    input  logic [muldiv_pkg::XLEN-1:0]   operand_b,
    input  logic                          res_ready,
    output logic                          in_ready,
    output logic                          res_valid,
    output logic [muldiv_pkg::HILO_W-1:0] hilo
);

    logic                          issue;
    logic                          dec_is_div;
    logic                          dec_is_move;
    logic                          dec_is_unsigned;
    muldiv_pkg::wb_kind_t          dec_wb_kind;
    logic [muldiv_pkg::XLEN-1:0]   dec_operand_a;
    logic [muldiv_pkg::XLEN-1:0]   dec_operand_b;
    logic                          ex_valid;
    logic [muldiv_pkg::HILO_W-1:0] ex_value;
    muldiv_pkg::wb_kind_t          ex_wb_kind;
    logic                          res_done;

    muldiv_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .in_valid      (in_valid),
        .op            (op),
        .is_unsigned   (is_unsigned),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .res_done      (res_done),
        .in_ready      (in_ready),
        .issue         (issue),
        .is_div        (dec_is_div),
        .is_move       (dec_is_move),
        .is_unsigned_q (dec_is_unsigned),
        .wb_kind       (dec_wb_kind),
        .operand_a_q   (dec_operand_a),
        .operand_b_q   (dec_operand_b)
    );

    muldiv_execute u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .issue       (issue),
        .is_div      (dec_is_div),
        .is_move     (dec_is_move),
        .is_unsigned (dec_is_unsigned),
        .wb_kind     (dec_wb_kind),
        .operand_a   (dec_operand_a),
        .operand_b   (dec_operand_b),
        .ex_valid    (ex_valid),
        .ex_value    (ex_value),
        .ex_wb_kind  (ex_wb_kind)
    );

    hilo_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_valid  (ex_valid),
        .ex_value  (ex_value),
        .wb_kind   (ex_wb_kind),
        .res_ready (res_ready),
        .res_valid (res_valid),
        .hilo      (hilo),
        .res_done  (res_done)
    );

endmodule

// ==== hw/seq_divider.sv ====
module seq_divider (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        abort,
    input  logic [muldiv_pkg::XLEN-1:0] dividend,
    input  logic [muldiv_pkg::XLEN-1:0] divisor,
    output logic [muldiv_pkg::XLEN-1:0] quotient,
    output logic [muldiv_pkg::XLEN-1:0] remainder,
    output logic                        done
);

    localparam int W = muldiv_pkg::XLEN;

    muldiv_pkg::div_cnt_t cnt;
    logic [W-1:0]         rem_q;
    logic [W-1:0]         quo_q;
    logic [W-1:0]         dvs_q;
    logic [W:0]           trial;

    // shift the next dividend bit into the partial remainder and try the subtraction,
    // a set top bit means the divisor did not fit
    assign trial = {rem_q, quo_q[W-1]} - {1'b0, dvs_q};

    assign quotient  = quo_q;
    assign remainder = rem_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt  <= '0;
            done <= 1'b0;
        end else if (abort) begin
            cnt  <= '0;
            done <= 1'b0;
        end else if (start) begin
            cnt  <= muldiv_pkg::div_cnt_t'(muldiv_pkg::DIV_CYCLES);
            done <= 1'b0;
        end else begin
            // done follows the last iteration by one edge
            done <= (cnt == muldiv_pkg::div_cnt_t'(1));
            if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // the dividend register doubles as the quotient shift register
    always_ff @(posedge clk) begin
        if (start) begin
            rem_q <= '0;
            quo_q <= dividend;
            dvs_q <= divisor;
        end else if (cnt != '0) begin
            if (!trial[W]) begin
                rem_q <= trial[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b1};
            end else begin
                rem_q <= {rem_q[W-2:0], quo_q[W-1]};
                quo_q <= {quo_q[W-2:0], 1'b0};
            end
        end
    end

endmodule

// ==== sim/clk_gen.sv ====
module clk_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam time HALF_PERIOD = 20ns;
    localparam int  RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset is released on a falling edge so the first active edge sees a clean value
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== sim/muldiv_asserts.sv ====
module muldiv_asserts (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          flush,
    input logic                          in_valid,
    input logic                          in_ready,
    input logic                          res_valid,
    input logic                          res_ready,
    input logic [muldiv_pkg::HILO_W-1:0] hilo
);

    timeunit 1ns;
    timeprecision 1ps;

    muldiv_pkg::div_cnt_t flush_window;

    // counts down the cycles after a flush in which no new result may appear,
    // a newly accepted request closes the window
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_window <= '0;
        end else if (flush) begin
            flush_window <= muldiv_pkg::div_cnt_t'(muldiv_pkg::DIV_CYCLES);
        end else if (in_valid && in_ready) begin
            flush_window <= '0;
        end else if (flush_window != '0) begin
            flush_window <= flush_window - 1'b1;
        end
    end

    result_held: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> res_valid && $stable(hilo))
        else $error("result changed while res_ready was low");

    no_accept_while_waiting: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> !in_ready)
        else $error("in_ready high while a result is waiting");

    no_result_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush_window != '0 |-> !$rose(res_valid))
        else $error("result appeared after a flush without a new request");

endmodule

// ==== sim/muldiv_stim.txt ====
# opcode unsigned operand_a operand_b flush_after expected_hilo (all hex except flush_after)
# opcodes 0 MULT 1 MADD 2 MSUB 3 DIV 4 MTHILO, expected_hilo is unused when flush_after is not 0
4 0 12345678 9abcdef0 0 123456789abcdef0
0 1 ffffffff ffffffff 0 fffffffe00000001
0 0 ffffffff 00000002 0 fffffffffffffffe
0 0 fffffffd fffffff9 0 0000000000000015
4 0 00000000 00000064 0 0000000000000064
1 0 fffffff6 00000003 0 0000000000000046
2 1 00000010 00000010 0 ffffffffffffff46
1 1 80000000 00000004 0 00000001ffffff46
3 1 00000064 00000007 0 000000020000000e
3 0 ffffff9c 00000007 0 fffffffefffffff2
3 0 00000064 fffffff9 0 00000002fffffff2
3 0 80000000 ffffffff 0 0000000080000000
3 1 12345678 00000000 0 12345678ffffffff
3 0 fffffff0 00000000 0 fffffff0ffffffff
3 0 00001000 00000003 10 0000000000000000
4 0 00000000 00000000 0 0000000000000000
1 1 00000006 00000007 0 000000000000002a

// ==== sim/muldiv_tb.sv ====
module muldiv_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 100;

    logic                          clk;
    logic                          rst_n;
    logic                          flush;
    logic                          in_valid;
    logic [muldiv_pkg::OP_W-1:0]   op;
    logic                          is_unsigned;
    logic [muldiv_pkg::XLEN-1:0]   operand_a;
    logic [muldiv_pkg::XLEN-1:0]   operand_b;
    logic                          res_ready;
    logic                          in_ready;
    logic                          res_valid;
    logic [muldiv_pkg::HILO_W-1:0] hilo;

    int                            errors;
    int                            tests_run;
    int                            tests_failed;
    logic [31:0]                   rng_state;
    logic [muldiv_pkg::HILO_W-1:0] hilo_exp;

    clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    muldiv_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .in_valid    (in_valid),
        .op          (op),
        .is_unsigned (is_unsigned),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .res_ready   (res_ready),
        .in_ready    (in_ready),
        .res_valid   (res_valid),
        .hilo        (hilo)
    );

    bind muldiv_top muldiv_asserts u_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .hilo      (hilo)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic string op_name(input logic [muldiv_pkg::OP_W-1:0] code);
        case (muldiv_pkg::op_t'(code))
            muldiv_pkg::OP_MULT:   return "MULT";
            muldiv_pkg::OP_MADD:   return "MADD";
            muldiv_pkg::OP_MSUB:   return "MSUB";
            muldiv_pkg::OP_DIV:    return "DIV";
            muldiv_pkg::OP_MTHILO: return "MTHILO";
            default:               return "UNKNOWN";
        endcase
    endfunction

    task automatic wait_in_ready(output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            seen = (in_ready === 1'b1);
            n++;
        end
    endtask

    task automatic wait_res_valid(output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            seen = (res_valid === 1'b1);
            n++;
        end
    endtask

    // after a flush the whole window must pass without a result
    task automatic watch_no_result(output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (n < WAIT_LIMIT) begin
            @(negedge clk);
            if (res_valid !== 1'b0) begin
                seen = 1'b1;
            end
            n++;
        end
    endtask

    task automatic hold_result(input int cycles);
        logic [muldiv_pkg::HILO_W-1:0] held;
        held = hilo;
        repeat (cycles) begin
            @(negedge clk);
            if (res_valid !== 1'b1) begin
                $display("res_valid dropped while res_ready was low");
                errors++;
            end
            if (hilo !== held) begin
                $display("Mismatch hilo: held 0x%h now 0x%h", held, hilo);
                errors++;
            end
            if (in_ready !== 1'b0) begin
                $display("in_ready rose while a result was waiting");
                errors++;
            end
        end
    endtask

    task automatic run_test(
        input  logic [muldiv_pkg::OP_W-1:0]   t_op,
        input  logic                          t_uns,
        input  logic [muldiv_pkg::XLEN-1:0]   t_a,
        input  logic [muldiv_pkg::XLEN-1:0]   t_b,
        input  int                            t_flush,
        input  logic [muldiv_pkg::HILO_W-1:0] t_exp,
        output bit                            stop
    );
        bit seen;
        int hold;
        stop = 1'b0;
        wait_in_ready(seen);
        if (!seen) begin
            $display("timeout: in_ready stayed low before test %0d", tests_run);
            errors++;
            stop = 1'b1;
        end else begin
            in_valid    = 1'b1;
            op          = t_op;
            is_unsigned = t_uns;
            operand_a   = t_a;
            operand_b   = t_b;
            // odd-numbered tests see back-pressure on the result
            res_ready   = (tests_run % 2 == 0);
            @(negedge clk);
            in_valid = 1'b0;
            if (t_flush > 0) begin
                repeat (t_flush - 1) @(negedge clk);
                flush = 1'b1;
                @(negedge clk);
                flush     = 1'b0;
                res_ready = 1'b1;
                watch_no_result(seen);
                if (seen) begin
                    $display("a result appeared after the flush of test %0d", tests_run);
                    errors++;
                end
                // an aborted operation leaves HI/LO as the last finished operation left it
                if (hilo !== hilo_exp) begin
                    $display("Mismatch hilo: expected 0x%h actual 0x%h", hilo_exp, hilo);
                    errors++;
                end
            end else begin
                wait_res_valid(seen);
                if (!seen) begin
                    $display("timeout: no result for test %0d", tests_run);
                    errors++;
                    stop = 1'b1;
                end else begin
                    if (hilo !== t_exp) begin
                        $display("Mismatch hilo: expected 0x%h actual 0x%h", t_exp, hilo);
                        errors++;
                    end
                    hilo_exp = t_exp;
                    if (!res_ready) begin
                        rng_state = xorshift32(rng_state);
                        hold      = int'(rng_state % 4) + 1;
                        hold_result(hold);
                        res_ready = 1'b1;
                    end
                end
            end
        end
    endtask

    initial begin
        int                            fd;
        int                            code;
        int                            n;
        int                            errs_before;
        string                         line;
        logic [muldiv_pkg::OP_W-1:0]   t_op;
        logic                          t_uns;
        logic [muldiv_pkg::XLEN-1:0]   t_a;
        logic [muldiv_pkg::XLEN-1:0]   t_b;
        int                            t_flush;
        logic [muldiv_pkg::HILO_W-1:0] t_exp;
        bit                            stop_run;

        flush        = 1'b0;
        in_valid     = 1'b0;
        op           = '0;
        is_unsigned  = 1'b0;
        operand_a    = '0;
        operand_b    = '0;
        res_ready    = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rng_state    = 32'd42873;
        hilo_exp     = '0;
        stop_run     = 1'b0;
        fd           = 0;

        n = 0;
        while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            errors++;
            stop_run = 1'b1;
        end else begin
            fd = $fopen("sim/muldiv_stim.txt", "r");
            if (fd == 0) begin
                $display("cannot open the stimulus file sim/muldiv_stim.txt");
                errors++;
                stop_run = 1'b1;
            end
        end

        while (!stop_run && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
                code = $sscanf(line, "%h %h %h %h %d %h", t_op, t_uns, t_a, t_b, t_flush, t_exp);
                if (code != 6) begin
                    $display("malformed stimulus line: %s", line);
                    errors++;
                end else begin
                    tests_run++;
                    errs_before = errors;
                    run_test(t_op, t_uns, t_a, t_b, t_flush, t_exp, stop_run);
                    if (errors != errs_before) begin
                        tests_failed++;
                    end
                    $display("test %0d %s a=0x%h b=0x%h: %s", tests_run, op_name(t_op),
                             t_a, t_b, (errors == errs_before) ? "ok" : "error");
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (tests_run == 0) begin
            $display("no tests were read from the stimulus file");
            errors++;
        end

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
